/* src.f */
common/harness_pkg.sv
slow_mem/latency_timer.sv
slow_mem/slow_mem_array.sv
slow_mem/slow_mem_ctrl.sv
logic/pwr_switch_model.sv
logic/ext_harness_top.sv
sim/tb_ext_harness.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log.
# Exits with status 1 if any step fails or the log reports a failure.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -f src.f --top-module tb_ext_harness \
  -Mdir "$BUILD_DIR" -o tb_ext_harness
if [ $? -ne 0 ]; then
  echo "run.sh: Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tb_ext_harness" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "run.sh: simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
  echo "run.sh: simulation reported failure"
  exit 1
fi

if ! grep -q "TEST PASSED" "$LOG"; then
  echo "run.sh: no result found in $LOG"
  exit 1
fi

exit 0

/* sim/tb_ext_harness.sv */
// Random OBI traffic and switch toggles checked against models in the testbench.
// Reads only hit words written earlier, since the memory contents have no reset.
`timescale 1ns/100ps
`default_nettype none

module tb_ext_harness;

  import harness_pkg::*;

  localparam int NUM_WORDS     = 128;
  localparam int MAX_GNT_DELAY = 7;
  localparam int ACK_LATENCY   = 15;
  localparam int IDX_W         = $clog2(NUM_WORDS);
  localparam int WAIT_LIMIT    = MAX_GNT_DELAY + 8;
  localparam int SW_W          = $bits(pwr_switch_t);

  logic        clk;
  logic        rst_n;
  obi_req_t    mem_req;
  obi_resp_t   mem_resp;
  pwr_switch_t pwr_switch;
  pwr_switch_t pwr_switch_ack;

  integer seed;
  int     num_checks;
  int     num_errors;
  int     tests_run;
  int     tests_failed;
  int     min_delay;
  int     max_delay;
  bit     timed_out;

  // Expected memory contents by word index
  logic [DATA_WIDTH-1:0] model_mem [int unsigned];
  // Last ACK_LATENCY values driven onto the switch lines
  pwr_switch_t           ack_hist [$];

  ext_harness_top #(
    .NUM_WORDS    (NUM_WORDS),
    .MAX_GNT_DELAY(MAX_GNT_DELAY),
    .ACK_LATENCY  (ACK_LATENCY)
  ) UUT (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .mem_req_i       (mem_req),
    .mem_resp_o      (mem_resp),
    .pwr_switch_i    (pwr_switch),
    .pwr_switch_ack_o(pwr_switch_ack)
  );

  always #10 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    num_checks++;
    if (got !== exp) begin
      num_errors++;
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic report_error(input string msg);
    num_errors++;
    $display("ERROR: %s at %0t", msg, $time);
  endtask

  task automatic finish_test(input string name, input int start_errors, input string detail);
    tests_run++;
    if (num_errors > start_errors) begin
      tests_failed++;
      $display("test %s: FAILED with %0d errors %s", name, num_errors - start_errors, detail);
    end else begin
      $display("test %s: passed %s", name, detail);
    end
  endtask

  function automatic logic [31:0] next_random();
    return $random(seed);
  endfunction

  // Upper address bits alias onto the same word
  function automatic int unsigned word_index(input logic [ADDR_WIDTH-1:0] addr);
    return (addr >> 2) % NUM_WORDS;
  endfunction

  function automatic logic [ADDR_WIDTH-1:0] word_addr(input int unsigned idx);
    logic [ADDR_WIDTH-1:0] addr;
    addr = idx;
    return addr << 2;
  endfunction

  function automatic logic [DATA_WIDTH-1:0] merge_bytes(input logic [DATA_WIDTH-1:0] old_word,
                                                        input logic [DATA_WIDTH-1:0] new_word,
                                                        input logic [BE_WIDTH-1:0] be);
    logic [DATA_WIDTH-1:0] result;
    result = old_word;
    for (int b = 0; b < BE_WIDTH; b++) begin
      if (be[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  task automatic check_outputs_zero();
    check_value("gnt", 32'(mem_resp.gnt), 32'd0);
    check_value("rvalid", 32'(mem_resp.rvalid), 32'd0);
    check_value("rdata", mem_resp.rdata, 32'd0);
    check_value("pwr_switch_ack_o", 32'(pwr_switch_ack), 32'd0);
  endtask

  // One OBI transfer with grant and response timing checks
  task automatic mem_access(input logic we, input logic [BE_WIDTH-1:0] be,
                            input logic [ADDR_WIDTH-1:0] addr,
                            input logic [DATA_WIDTH-1:0] wdata,
                            input logic [DATA_WIDTH-1:0] exp_rdata);
    int cycles;
    bit seen;
    if (!timed_out) begin
      @(posedge clk);
      mem_req <= '{req: 1'b1, we: we, be: be, addr: addr, wdata: wdata};
      cycles = 0;
      seen = 1'b0;
      while (!seen && cycles <= WAIT_LIMIT) begin
        @(negedge clk);
        if (mem_resp.gnt) begin
          seen = 1'b1;
        end else begin
          check_value("rvalid", 32'(mem_resp.rvalid), 32'd0);
          cycles++;
        end
      end
      if (!seen) begin
        report_error($sformatf("no gnt within %0d cycles of req", WAIT_LIMIT));
        timed_out = 1'b1;
      end else begin
        if (cycles < 1 || cycles > MAX_GNT_DELAY) begin
          report_error($sformatf("gnt came %0d cycles after req, outside 1 to %0d",
                                 cycles, MAX_GNT_DELAY));
        end
        if (cycles < min_delay) begin
          min_delay = cycles;
        end
        if (cycles > max_delay) begin
          max_delay = cycles;
        end
        @(posedge clk);
        mem_req.req <= 1'b0;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < WAIT_LIMIT) begin
          @(negedge clk);
          cycles++;
          if (mem_resp.rvalid) begin
            seen = 1'b1;
          end
        end
        if (!seen) begin
          report_error($sformatf("no rvalid within %0d cycles of gnt", WAIT_LIMIT));
          timed_out = 1'b1;
        end else begin
          check_value("rvalid delay after gnt", 32'(cycles), 32'd1);
          check_value("gnt", 32'(mem_resp.gnt), 32'd0);
          check_value("rdata", mem_resp.rdata, exp_rdata);
          // rvalid is a single pulse
          @(negedge clk);
          check_value("rvalid", 32'(mem_resp.rvalid), 32'd0);
          check_value("gnt", 32'(mem_resp.gnt), 32'd0);
        end
      end
    end
  endtask

  task automatic write_word(input logic [ADDR_WIDTH-1:0] addr, input logic [BE_WIDTH-1:0] be,
                            input logic [DATA_WIDTH-1:0] wdata);
    int unsigned           idx;
    logic [DATA_WIDTH-1:0] old_word;
    idx = word_index(addr);
    old_word = model_mem.exists(idx) ? model_mem[idx] : '0;
    model_mem[idx] = merge_bytes(old_word, wdata, be);
    mem_access(1'b1, be, addr, wdata, '0);
  endtask

  task automatic read_word(input logic [ADDR_WIDTH-1:0] addr);
    // Write data on a read is noise and must be ignored
    mem_access(1'b0, '1, addr, next_random(), model_mem[word_index(addr)]);
  endtask

  task automatic run_reset_test();
    int          start_errors;
    logic [31:0] r;
    start_errors = num_errors;
    // Nonzero switch requests while the chain is held clear
    for (int i = 0; i < 4; i++) begin
      @(posedge clk);
      r = next_random();
      pwr_switch <= r[SW_W-1:0] | SW_W'(1);
      @(negedge clk);
      check_outputs_zero();
    end
    @(posedge clk);
    rst_n <= 1'b1;
    pwr_switch <= '0;
    @(negedge clk);
    check_outputs_zero();
    // Requests seen during reset never reach the acknowledges
    for (int i = 1; i < ACK_LATENCY; i++) begin
      @(negedge clk);
      check_value("pwr_switch_ack_o", 32'(pwr_switch_ack), 32'd0);
    end
    finish_test("reset values", start_errors, "");
  endtask

  task automatic run_rw_test();
    int          start_errors;
    int unsigned idx;
    logic [31:0] r;
    start_errors = num_errors;
    for (int n = 0; n < 200; n++) begin
      idx = next_random() % NUM_WORDS;
      r = next_random();
      if (!model_mem.exists(idx) || r[0]) begin
        write_word(word_addr(idx), '1, next_random());
      end else begin
        read_word(word_addr(idx));
      end
    end
    finish_test("random reads and writes", start_errors, "");
  endtask

  task automatic run_byte_enable_test();
    int          start_errors;
    int unsigned idx;
    logic [31:0] r;
    start_errors = num_errors;
    for (int n = 0; n < 60; n++) begin
      idx = next_random() % NUM_WORDS;
      if (!model_mem.exists(idx)) begin
        write_word(word_addr(idx), '1, next_random());
      end
      r = next_random();
      write_word(word_addr(idx), r[BE_WIDTH-1:0], next_random());
      read_word(word_addr(idx));
    end
    finish_test("byte enables", start_errors, "");
  endtask

  task automatic run_alias_test();
    int                    start_errors;
    logic [ADDR_WIDTH-1:0] a1;
    logic [ADDR_WIDTH-1:0] flip;
    start_errors = num_errors;
    for (int n = 0; n < 30; n++) begin
      a1 = next_random();
      a1[1:0] = 2'b00;
      // Flip only bits above the word index, at least one
      flip = next_random();
      flip[IDX_W+1:0] = '0;
      flip[IDX_W+2] = 1'b1;
      write_word(a1, '1, next_random());
      read_word(a1 ^ flip);
    end
    finish_test("address aliasing", start_errors, "");
  endtask

  task automatic run_timing_test();
    int          start_errors;
    int unsigned idx;
    start_errors = num_errors;
    min_delay = WAIT_LIMIT + 1;
    max_delay = 0;
    for (int n = 0; n < 100; n++) begin
      idx = next_random() % NUM_WORDS;
      if (model_mem.exists(idx)) begin
        read_word(word_addr(idx));
      end else begin
        write_word(word_addr(idx), '1, next_random());
      end
    end
    finish_test("grant and response timing", start_errors,
                $sformatf("(gnt delays %0d to %0d cycles)", min_delay, max_delay));
  endtask

  task automatic run_switch_test();
    int          start_errors;
    logic [31:0] r;
    pwr_switch_t drive_val;
    pwr_switch_t expected;
    start_errors = num_errors;
    // Lines have been low for far longer than the chain depth
    ack_hist.delete();
    for (int i = 0; i < ACK_LATENCY; i++) begin
      ack_hist.push_back('0);
    end
    for (int n = 0; n < 300; n++) begin
      @(posedge clk);
      expected = ack_hist.pop_front();
      r = next_random();
      drive_val = r[SW_W-1:0];
      pwr_switch <= drive_val;
      ack_hist.push_back(drive_val);
      @(negedge clk);
      check_value("pwr_switch_ack_o", 32'(pwr_switch_ack), 32'(expected));
    end
    finish_test("switch acknowledges", start_errors, "");
  endtask

  initial begin
    seed = 32'hbf1315bc;
    clk = 1'b0;
    rst_n = 1'b0;
    mem_req = '0;
    pwr_switch = '0;
    num_checks = 0;
    num_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    min_delay = WAIT_LIMIT + 1;
    max_delay = 0;
    timed_out = 1'b0;

    run_reset_test();
    run_rw_test();
    run_byte_enable_test();
    run_alias_test();
    run_timing_test();
    run_switch_test();

    $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, num_checks, num_errors);
    if (num_errors == 0 && !timed_out) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* logic/ext_harness_top.sv */
// Slow OBI memory and power switch acknowledge model.
// The memory answers every address; only the word index bits are decoded.
`timescale 1ns/100ps
`default_nettype none

module ext_harness_top #(
  parameter int unsigned NUM_WORDS     = 128,
  parameter int unsigned MAX_GNT_DELAY = 7,
  parameter int unsigned ACK_LATENCY   = 15
) (
  input  wire                      clk_i,
  input  wire                      rst_n_i,
  input  harness_pkg::obi_req_t    mem_req_i,
  output harness_pkg::obi_resp_t   mem_resp_o,
  input  harness_pkg::pwr_switch_t pwr_switch_i,
  output harness_pkg::pwr_switch_t pwr_switch_ack_o
);

  import harness_pkg::*;

  logic                  timer_start;
  logic                  timer_done;
  logic                  gnt;
  logic                  rvalid;
  logic                  wr_en;
  logic                  rd_en;
  logic [DATA_WIDTH-1:0] rdata;

  slow_mem_ctrl slow_mem_ctrl_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .mem_req_i    (mem_req_i),
    .timer_done_i (timer_done),
    .timer_start_o(timer_start),
    .gnt_o        (gnt),
    .rvalid_o     (rvalid),
    .wr_en_o      (wr_en),
    .rd_en_o      (rd_en)
  );

  latency_timer #(
    .MAX_GNT_DELAY(MAX_GNT_DELAY)
  ) latency_timer_i (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .start_i(timer_start),
    .done_o (timer_done)
  );

  slow_mem_array #(
    .NUM_WORDS(NUM_WORDS)
  ) slow_mem_array_i (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .wr_en_i(wr_en),
    .rd_en_i(rd_en),
    .addr_i (mem_req_i.addr),
    .be_i   (mem_req_i.be),
    .wdata_i(mem_req_i.wdata),
    .rdata_o(rdata)
  );

  assign mem_resp_o = '{gnt: gnt, rvalid: rvalid, rdata: rdata};

  pwr_switch_model #(
    .ACK_LATENCY(ACK_LATENCY)
  ) pwr_switch_model_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .switch_i(pwr_switch_i),
    .ack_o   (pwr_switch_ack_o)
  );

endmodule

`default_nettype wire

/* logic/pwr_switch_model.sv */
// Switch cell model, every line acknowledged ACK_LATENCY cycles later.
// ACK_LATENCY must be at least one.
`timescale 1ns/100ps
`default_nettype none

module pwr_switch_model #(
  parameter int unsigned ACK_LATENCY = 15
) (
  input  wire                     clk_i,
  input  wire                     rst_n_i,
  input  harness_pkg::pwr_switch_t switch_i,
  output harness_pkg::pwr_switch_t ack_o
);

  import harness_pkg::*;

  pwr_switch_t stage_q [ACK_LATENCY];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < ACK_LATENCY; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= switch_i;
      for (int i = 1; i < ACK_LATENCY; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  // Settled acknowledge
  assign ack_o = stage_q[ACK_LATENCY-1];

endmodule

`default_nettype wire

/* slow_mem/slow_mem_ctrl.sv */
// OBI slave control, one request outstanding at a time.
// gnt waits on the latency timer; rvalid follows gnt by one cycle.
`timescale 1ns/100ps
`default_nettype none

module slow_mem_ctrl (
  input  wire                  clk_i,
  input  wire                  rst_n_i,
  input  harness_pkg::obi_req_t mem_req_i,
  input  wire                  timer_done_i,
  output logic                 timer_start_o,
  output logic                 gnt_o,
  output logic                 rvalid_o,
  output logic                 wr_en_o,
  output logic                 rd_en_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,
    ST_RESP
  } state_e;

  state_e state_q;
  state_e state_d;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d       = state_q;
    timer_start_o = 1'b0;
    gnt_o         = 1'b0;
    rvalid_o      = 1'b0;
    wr_en_o       = 1'b0;
    rd_en_o       = 1'b0;

    unique case (state_q)
      ST_IDLE: begin
        // Delay is drawn the cycle req is first seen
        if (mem_req_i.req) begin
          timer_start_o = 1'b1;
          state_d       = ST_WAIT;
        end
      end

      ST_WAIT: begin
        if (timer_done_i) begin
          gnt_o   = 1'b1;
          wr_en_o = mem_req_i.we;
          rd_en_o = ~mem_req_i.we;
          state_d = ST_RESP;
        end
      end

      ST_RESP: begin
        // No back-pressure on the response
        rvalid_o = 1'b1;
        state_d  = ST_IDLE;
      end

      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

endmodule

`default_nettype wire

/* slow_mem/slow_mem_array.sv */
// Word memory, NUM_WORDS a power of two; upper address bits are ignored.
// Contents are not reset, so a word must be written before it is read.
`timescale 1ns/100ps
`default_nettype none

module slow_mem_array #(
  parameter int unsigned NUM_WORDS = 128
) (
  input  wire                                clk_i,
  input  wire                                rst_n_i,
  input  wire                                wr_en_i,
  input  wire                                rd_en_i,
  input  wire  [harness_pkg::ADDR_WIDTH-1:0] addr_i,
  input  wire  [harness_pkg::BE_WIDTH-1:0]   be_i,
  input  wire  [harness_pkg::DATA_WIDTH-1:0] wdata_i,
  output logic [harness_pkg::DATA_WIDTH-1:0] rdata_o
);

  import harness_pkg::*;

  localparam int unsigned IDX_W = $clog2(NUM_WORDS);

  logic [DATA_WIDTH-1:0] mem [NUM_WORDS];
  logic [IDX_W-1:0]      idx;

  // Word index starts above the byte offset
  assign idx = addr_i[IDX_W+1:2];

  always_ff @(posedge clk_i) begin
    for (int b = 0; b < BE_WIDTH; b++) begin
      if (wr_en_i && be_i[b]) begin
        mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
      end
    end
  end

  // Zero outside the response cycle of a read
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rdata_o <= '0;
    end else if (rd_en_i) begin
      rdata_o <= mem[idx];
    end else begin
      rdata_o <= '0;
    end
  end

endmodule

`default_nettype wire

/* slow_mem/latency_timer.sv */
// Random grant delay of 1 to MAX_GNT_DELAY cycles.
// start_i must not come while a countdown is running.
`timescale 1ns/100ps
`default_nettype none

module latency_timer #(
  parameter int unsigned MAX_GNT_DELAY = 7
) (
  input  wire  clk_i,
  input  wire  rst_n_i,
  input  wire  start_i,
  output logic done_o
);

  localparam int unsigned CNT_W = $clog2(MAX_GNT_DELAY + 1);
  localparam logic [15:0] MAX_D = 16'(MAX_GNT_DELAY);

  logic [15:0]      lfsr_q;
  logic             lfsr_fb;
  logic [15:0]      delay;
  logic [CNT_W-1:0] cnt_q;

  // x^16 + x^14 + x^13 + x^11 + 1, free running
  assign lfsr_fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
  assign delay   = (lfsr_q % MAX_D) + 16'd1;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lfsr_q <= 16'hace1;
      cnt_q  <= '0;
    end else begin
      lfsr_q <= {lfsr_q[14:0], lfsr_fb};
      if (start_i) begin
        cnt_q <= delay[CNT_W-1:0];
      end else if (cnt_q != '0) begin
        cnt_q <= cnt_q - CNT_W'(1);
      end
    end
  end

  // Last count, d cycles after start
  assign done_o = (cnt_q == CNT_W'(1));

endmodule

`default_nettype wire

/* common/harness_pkg.sv */
// Bus widths and packed types for the external harness.
// Data width must be a multiple of eight, one byte enable per byte.
`default_nettype none

package harness_pkg;

  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned BE_WIDTH = DATA_WIDTH / 8;

  // Power domains with a switch line
  localparam int unsigned NUM_BANKS = 2;
  localparam int unsigned EXT_DOMAINS = 1;

  // OBI request, held stable by the requester until gnt
  typedef struct packed {
    logic                  req;
    logic                  we;
    logic [BE_WIDTH-1:0]   be;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] wdata;
  } obi_req_t;

  // OBI response, rvalid comes the cycle after gnt
  typedef struct packed {
    logic                  gnt;
    logic                  rvalid;
    logic [DATA_WIDTH-1:0] rdata;
  } obi_resp_t;

  // Switch requests in, acknowledges out
  typedef struct packed {
    logic                   cpu;
    logic                   periph;
    logic [NUM_BANKS-1:0]   banks;
    logic [EXT_DOMAINS-1:0] ext;
  } pwr_switch_t;

endpackage

`default_nettype wire
